// ==== filelist.f ====
common/csr_pkg.sv
common/csr_write_if.sv
rtl/csr_except_regs.sv
rtl/csr_intr_regs.sv
rtl/csr_timer.sv
rtl/csr_save_regs.sv
rtl/csr_top.sv
testbench/csr_tb.sv

// ==== testbench/csr_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_tb import csr_pkg::*; ();

    localparam int          TIMEOUT_CYCLES = 64;
    localparam logic [29:0] TIMER_INIT     = 30'd2;

    typedef enum logic [2:0] {
        STEP_WRITE,
        STEP_CHECK,
        STEP_EXCEPT,
        STEP_RETURN,
        STEP_WAIT_INT
    } step_kind_e;

    // For a check step the mask selects the compared bits
    typedef struct packed {
        step_kind_e kind;
        csr_num_t   num;
        csr_word_t  mask;
        csr_word_t  value;
        csr_word_t  pc;
        ecode_t     ecode;
        esubcode_t  esubcode;
        csr_word_t  expected;
    } step_t;

    logic       clk;
    logic       reset;
    csr_num_t   csr_num;
    csr_word_t  csr_rvalue;
    logic       csr_we;
    csr_word_t  csr_wmask;
    csr_word_t  csr_wvalue;
    logic       wb_ex;
    logic       ertn_flush;
    csr_word_t  wb_pc;
    ecode_t     wb_ecode;
    esubcode_t  wb_esubcode;
    logic [7:0] hw_int_in;
    logic       ipi_int_in;
    logic       has_int;
    csr_word_t  ex_entry;
    csr_word_t  ertn_entry;
    plv_t       crmd_plv;

    step_t       steps[$];
    csr_word_t   shadow [0:127];
    logic [31:0] lfsr_state;
    int          check_errors;
    int          timeout_errors;

    csr_top #(
        .NUM_SAVE (4)
    ) csr_top_inst (
        .clk         (clk),
        .reset       (reset),
        .csr_num     (csr_num),
        .csr_rvalue  (csr_rvalue),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .ertn_flush  (ertn_flush),
        .wb_pc       (wb_pc),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .has_int     (has_int),
        .ex_entry    (ex_entry),
        .ertn_entry  (ertn_entry),
        .crmd_plv    (crmd_plv)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps at bits 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_random_word(output csr_word_t word);
        word = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            word = {word[30:0], lfsr_state[0]};
        end
    endtask

    function automatic csr_word_t writable_bits(input csr_num_t num);
        case (num)
            CSR_CRMD, CSR_PRMD:  return 32'h0000_0007;
            CSR_ECFG:            return 32'h0000_1bff;
            CSR_ESTAT:           return 32'h0000_0003;
            CSR_EENTRY:          return 32'hffff_ffc0;
            CSR_TVAL, CSR_TICLR: return 32'h0000_0000;
            default:             return 32'hffff_ffff;
        endcase
    endfunction

    task automatic shadow_write(input csr_num_t num, input csr_word_t mask, input csr_word_t value);
        csr_word_t merged;
        merged = (mask & value) | (~mask & shadow[num[6:0]]);
        shadow[num[6:0]] = merged & writable_bits(num);
    endtask

    task automatic append_write(input csr_num_t num, input csr_word_t mask, input csr_word_t value);
        step_t s;
        s = '0;
        s.kind  = STEP_WRITE;
        s.num   = num;
        s.mask  = mask;
        s.value = value;
        steps.push_back(s);
        shadow_write(num, mask, value);
    endtask

    task automatic expect_bits(input csr_num_t num, input csr_word_t mask, input csr_word_t expected);
        step_t s;
        s = '0;
        s.kind     = STEP_CHECK;
        s.num      = num;
        s.mask     = mask;
        s.expected = expected & mask;
        steps.push_back(s);
    endtask

    task automatic expect_reg(input csr_num_t num);
        expect_bits(num, 32'hffff_ffff, shadow[num[6:0]]);
    endtask

    task automatic raise_exception(input csr_word_t pc, input ecode_t ecode, input esubcode_t esub);
        step_t s;
        s = '0;
        s.kind     = STEP_EXCEPT;
        s.pc       = pc;
        s.ecode    = ecode;
        s.esubcode = esub;
        s.expected = shadow[CSR_EENTRY];
        steps.push_back(s);
        shadow[CSR_PRMD] = shadow[CSR_CRMD] & 32'h7;
        shadow[CSR_CRMD] = '0;
        shadow[CSR_ERA]  = pc;
    endtask

    task automatic return_from_exception();
        step_t s;
        shadow[CSR_CRMD] = shadow[CSR_PRMD] & 32'h7;
        s = '0;
        s.kind     = STEP_RETURN;
        s.value    = shadow[CSR_CRMD];
        s.expected = shadow[CSR_ERA];
        steps.push_back(s);
    endtask

    task automatic await_interrupt(input logic [7:0] hw, input logic level);
        step_t s;
        s = '0;
        s.kind     = STEP_WAIT_INT;
        s.value    = {24'h0, hw};
        s.expected = {31'h0, level};
        steps.push_back(s);
    endtask

    task automatic build_table();
        csr_word_t mask;
        csr_word_t value;
        expect_reg(CSR_CRMD);
        expect_reg(CSR_ECFG);
        expect_bits(CSR_ESTAT, 32'h0000_0803, 32'h0);
        expect_bits(CSR_TVAL, 32'hffff_ffff, 32'hffff_ffff);
        await_interrupt(8'h00, 1'b0);
        for (int i = 0; i < 4; i++) begin
            next_random_word(value);
            append_write(csr_num_t'(CSR_SAVE0 + i), 32'hffff_ffff, value);
            expect_reg(csr_num_t'(CSR_SAVE0 + i));
        end
        for (int i = 0; i < 4; i++) begin
            next_random_word(mask);
            next_random_word(value);
            append_write(csr_num_t'(CSR_SAVE0 + i), mask, value);
        end
        for (int i = 0; i < 4; i++) begin
            expect_reg(csr_num_t'(CSR_SAVE0 + i));
        end
        append_write(CSR_CRMD, 32'hffff_ffff, 32'hffff_ffff);
        expect_reg(CSR_CRMD);
        append_write(CSR_CRMD, 32'h3, 32'h1);
        expect_reg(CSR_CRMD);
        append_write(CSR_CRMD, 32'h3, 32'h3);
        expect_reg(CSR_CRMD);
        append_write(CSR_ECFG, 32'hffff_ffff, 32'hffff_ffff);
        expect_reg(CSR_ECFG);
        append_write(CSR_EENTRY, 32'hffff_ffff, 32'h1c00_00ff);
        expect_reg(CSR_EENTRY);
        append_write(CSR_PRMD, 32'hffff_ffff, 32'h0);
        raise_exception(32'h1c00_1234, 6'h08, 9'h005);
        expect_reg(CSR_CRMD);
        expect_reg(CSR_PRMD);
        expect_reg(CSR_ERA);
        expect_bits(CSR_ESTAT, 32'h7fff_0000, {1'b0, 9'h005, 6'h08, 16'h0});
        return_from_exception();
        expect_reg(CSR_CRMD);
        // Hardware line 2 lands in ESTAT bit 4
        await_interrupt(8'h04, 1'b1);
        expect_bits(CSR_ESTAT, 32'h0000_1fff, 32'h0000_0010);
        append_write(CSR_ECFG, 32'h10, 32'h0);
        expect_reg(CSR_ECFG);
        await_interrupt(8'h04, 1'b0);
        append_write(CSR_TCFG, 32'hffff_ffff, {TIMER_INIT, 1'b0, 1'b1});
        expect_bits(CSR_TVAL, 32'hffff_ffff, {TIMER_INIT, 2'b00});
        expect_bits(CSR_TVAL, 32'hffff_ffff, {TIMER_INIT, 2'b00} - 32'd1);
        expect_reg(CSR_TCFG);
        await_interrupt(8'h00, 1'b1);
        expect_bits(CSR_ESTAT, 32'h0000_0800, 32'h0000_0800);
        expect_bits(CSR_TVAL, 32'hffff_ffff, 32'hffff_ffff);
        append_write(CSR_TICLR, 32'h1, 32'h1);
        expect_bits(CSR_ESTAT, 32'h0000_0800, 32'h0);
        expect_reg(CSR_TICLR);
        await_interrupt(8'h00, 1'b0);
        append_write(CSR_TCFG, 32'hffff_ffff, {TIMER_INIT, 1'b1, 1'b1});
        await_interrupt(8'h00, 1'b1);
        append_write(CSR_TICLR, 32'h1, 32'h1);
        expect_bits(CSR_ESTAT, 32'h0000_0800, 32'h0);
        await_interrupt(8'h00, 1'b1);
    endtask

    task automatic report_mismatch(input string what, input csr_word_t got, input csr_word_t exp);
        check_errors++;
        $display("CHECK FAILED at %0t ns: %s read %h, expected %h", $time, what, got, exp);
    endtask

    task automatic wait_for_has_int(input logic [7:0] hw, input logic level);
        int   cycles;
        logic seen;
        hw_int_in = hw;
        cycles    = 0;
        seen      = 1'b0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            #1;
            if (has_int === level) begin
                seen = 1'b1;
            end
            @(negedge clk);
            cycles++;
        end
        if (!seen) begin
            timeout_errors++;
            $display("Timeout at %0t ns: has_int did not become %0b within %0d cycles",
                     $time, level, TIMEOUT_CYCLES);
        end
    endtask

    // Every step starts just after a falling edge and ends on one
    task automatic run_step(input step_t s);
        csr_we     = 1'b0;
        wb_ex      = 1'b0;
        ertn_flush = 1'b0;
        csr_num    = s.num;
        case (s.kind)
            STEP_WRITE: begin
                csr_we     = 1'b1;
                csr_wmask  = s.mask;
                csr_wvalue = s.value;
                @(negedge clk);
            end
            STEP_CHECK: begin
                #1;
                if ((csr_rvalue & s.mask) !== s.expected) begin
                    report_mismatch($sformatf("CSR 0x%h", s.num), csr_rvalue & s.mask, s.expected);
                end
                @(negedge clk);
            end
            STEP_EXCEPT: begin
                wb_ex       = 1'b1;
                wb_pc       = s.pc;
                wb_ecode    = s.ecode;
                wb_esubcode = s.esubcode;
                #1;
                if (ex_entry !== s.expected) begin
                    report_mismatch("ex_entry", ex_entry, s.expected);
                end
                @(negedge clk);
            end
            STEP_RETURN: begin
                ertn_flush = 1'b1;
                #1;
                if (ertn_entry !== s.expected) begin
                    report_mismatch("ertn_entry", ertn_entry, s.expected);
                end
                @(negedge clk);
                if (crmd_plv !== s.value[1:0]) begin
                    report_mismatch("crmd_plv", {30'h0, crmd_plv}, {30'h0, s.value[1:0]});
                end
            end
            default: begin
                wait_for_has_int(s.value[7:0], s.expected[0]);
            end
        endcase
    endtask

    initial begin
        reset          = 1'b1;
        csr_num        = '0;
        csr_we         = 1'b0;
        csr_wmask      = '0;
        csr_wvalue     = '0;
        wb_ex          = 1'b0;
        ertn_flush     = 1'b0;
        wb_pc          = '0;
        wb_ecode       = '0;
        wb_esubcode    = '0;
        hw_int_in      = '0;
        ipi_int_in     = 1'b0;
        lfsr_state     = 32'h50b8;
        check_errors   = 0;
        timeout_errors = 0;
        for (int i = 0; i < 128; i++) begin
            shadow[i] = '0;
        end
        build_table();
        repeat (4) @(negedge clk);
        reset = 1'b0;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        csr_we = 1'b0;
        $display("Errors: %0d check failures, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/csr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_top import csr_pkg::*; #(
    parameter int NUM_SAVE = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  csr_num_t   csr_num,
    output csr_word_t  csr_rvalue,
    input  logic       csr_we,
    input  csr_word_t  csr_wmask,
    input  csr_word_t  csr_wvalue,
    input  logic       wb_ex,
    input  logic       ertn_flush,
    input  csr_word_t  wb_pc,
    input  ecode_t     wb_ecode,
    input  esubcode_t  wb_esubcode,
    input  logic [7:0] hw_int_in,
    input  logic       ipi_int_in,
    output logic       has_int,
    output csr_word_t  ex_entry,
    output csr_word_t  ertn_entry,
    output plv_t       crmd_plv
);

    csr_word_t except_rdata;
    csr_word_t intr_rdata;
    csr_word_t timer_rdata;
    csr_word_t save_rdata;
    logic      crmd_ie;
    logic      timer_int_set;
    logic      ticlr_clr;

    csr_write_if wr_if ();

    assign wr_if.we     = csr_we;
    assign wr_if.num    = csr_num;
    assign wr_if.wmask  = csr_wmask;
    assign wr_if.wvalue = csr_wvalue;

    csr_except_regs csr_except_regs_inst (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr_if),
        .csr_num    (csr_num),
        .wb_ex      (wb_ex),
        .ertn_flush (ertn_flush),
        .wb_pc      (wb_pc),
        .rdata      (except_rdata),
        .crmd_plv   (crmd_plv),
        .crmd_ie    (crmd_ie),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry)
    );

    csr_intr_regs csr_intr_regs_inst (
        .clk           (clk),
        .reset         (reset),
        .wr            (wr_if),
        .csr_num       (csr_num),
        .crmd_ie       (crmd_ie),
        .wb_ex         (wb_ex),
        .wb_ecode      (wb_ecode),
        .wb_esubcode   (wb_esubcode),
        .hw_int_in     (hw_int_in),
        .ipi_int_in    (ipi_int_in),
        .timer_int_set (timer_int_set),
        .ticlr_clr     (ticlr_clr),
        .rdata         (intr_rdata),
        .has_int       (has_int)
    );

    csr_timer csr_timer_inst (
        .clk           (clk),
        .reset         (reset),
        .wr            (wr_if),
        .csr_num       (csr_num),
        .rdata         (timer_rdata),
        .timer_int_set (timer_int_set),
        .ticlr_clr     (ticlr_clr)
    );

    csr_save_regs #(
        .NUM_SAVE (NUM_SAVE)
    ) csr_save_regs_inst (
        .clk     (clk),
        .wr      (wr_if),
        .csr_num (csr_num),
        .rdata   (save_rdata)
    );

    // Each group returns zero for numbers it does not own
    assign csr_rvalue = except_rdata | intr_rdata | timer_rdata | save_rdata;

endmodule

`default_nettype wire

// ==== rtl/csr_save_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_save_regs import csr_pkg::*; #(
    parameter int NUM_SAVE = 4
) (
    input  logic      clk,
    csr_write_if.sink wr,
    input  csr_num_t  csr_num,
    output csr_word_t rdata
);

    csr_word_t save_mem [NUM_SAVE];

    // Scratch words sit at consecutive numbers starting at SAVE0
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (wr.we && (wr.num == csr_num_t'(CSR_SAVE0 + i))) begin
                save_mem[i] <= masked_write(save_mem[i], wr.wmask, wr.wvalue);
            end
        end
    end

    always_comb begin
        rdata = '0;
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (csr_num == csr_num_t'(CSR_SAVE0 + i)) begin
                rdata = save_mem[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/csr_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_timer import csr_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    csr_write_if.sink wr,
    input  csr_num_t  csr_num,
    output csr_word_t rdata,
    output logic      timer_int_set,
    output logic      ticlr_clr
);

    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    csr_word_t   timer_cnt;
    csr_word_u   tcfg_view;
    csr_word_u   tcfg_next;
    logic        wr_tcfg;

    always_comb begin
        tcfg_view              = '0;
        tcfg_view.tcfg.en       = tcfg_en;
        tcfg_view.tcfg.periodic = tcfg_periodic;
        tcfg_view.tcfg.initval  = tcfg_initval;
    end

    assign wr_tcfg       = wr.we && (wr.num == CSR_TCFG);
    assign tcfg_next.raw = masked_write(tcfg_view.raw, wr.wmask, wr.wvalue);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en <= 1'b0;
        end else if (wr_tcfg) begin
            tcfg_en <= tcfg_next.tcfg.en;
        end
        if (wr_tcfg) begin
            tcfg_periodic <= tcfg_next.tcfg.periodic;
            tcfg_initval  <= tcfg_next.tcfg.initval;
        end
    end

    // A one-shot count runs past zero into TIMER_IDLE and stops there
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= TIMER_IDLE;
        end else if (wr_tcfg && tcfg_next.tcfg.en) begin
            timer_cnt <= {tcfg_next.tcfg.initval, 2'b00};
        end else if (tcfg_en && (timer_cnt != TIMER_IDLE)) begin
            if ((timer_cnt == '0) && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b00};
            end else begin
                timer_cnt <= timer_cnt - 1'b1;
            end
        end
    end

    assign timer_int_set = (timer_cnt == '0);
    assign ticlr_clr     = wr.we && (wr.num == CSR_TICLR) && wr.wmask[0] && wr.wvalue[0];

    // TICLR falls through to the default and reads zero
    always_comb begin
        case (csr_num)
            CSR_TCFG: rdata = tcfg_view.raw;
            CSR_TVAL: rdata = timer_cnt;
            default:  rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/csr_intr_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_intr_regs import csr_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    csr_write_if.sink  wr,
    input  csr_num_t   csr_num,
    input  logic       crmd_ie,
    input  logic       wb_ex,
    input  ecode_t     wb_ecode,
    input  esubcode_t  wb_esubcode,
    input  logic [7:0] hw_int_in,
    input  logic       ipi_int_in,
    input  logic       timer_int_set,
    input  logic       ticlr_clr,
    output csr_word_t  rdata,
    output logic       has_int
);

    logic [INT_NUM-1:0] ecfg_lie;
    logic [1:0]         sw_int;
    logic [7:0]         hw_int;
    logic               timer_int;
    logic               ipi_int;
    ecode_t             estat_ecode;
    esubcode_t          estat_esubcode;
    logic [INT_NUM-1:0] int_status;
    csr_word_u          estat_view;
    csr_word_u          estat_next;
    csr_word_t          ecfg_next;

    // Bit 10 is never set
    always_comb begin
        int_status                    = '0;
        int_status[1:0]               = sw_int;
        int_status[HW_INT_LSB +: 8]   = hw_int;
        int_status[TIMER_INT_BIT]     = timer_int;
        int_status[IPI_INT_BIT]       = ipi_int;
        estat_view                = '0;
        estat_view.estat.is       = int_status;
        estat_view.estat.ecode    = estat_ecode;
        estat_view.estat.esubcode = estat_esubcode;
    end

    assign ecfg_next      = masked_write({{(32-INT_NUM){1'b0}}, ecfg_lie}, wr.wmask, wr.wvalue);
    assign estat_next.raw = masked_write(estat_view.raw, wr.wmask, wr.wvalue);

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie  <= '0;
            sw_int    <= '0;
            timer_int <= 1'b0;
        end else begin
            if (wr.we && (wr.num == CSR_ECFG)) begin
                ecfg_lie <= ecfg_next[INT_NUM-1:0] & ECFG_LIE_MASK;
            end
            if (wr.we && (wr.num == CSR_ESTAT)) begin
                sw_int <= estat_next.estat.is[1:0];
            end
            // A timer expiry in the same cycle overrides the clear
            if (timer_int_set) begin
                timer_int <= 1'b1;
            end else if (ticlr_clr) begin
                timer_int <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        hw_int  <= hw_int_in;
        ipi_int <= ipi_int_in;
        if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end
    end

    assign has_int = ((int_status & ecfg_lie) != '0) && crmd_ie;

    always_comb begin
        case (csr_num)
            CSR_ECFG:  rdata = {{(32-INT_NUM){1'b0}}, ecfg_lie};
            CSR_ESTAT: rdata = estat_view.raw;
            default:   rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/csr_except_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_except_regs import csr_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    csr_write_if.sink  wr,
    input  csr_num_t   csr_num,
    input  logic       wb_ex,
    input  logic       ertn_flush,
    input  csr_word_t  wb_pc,
    output csr_word_t  rdata,
    output plv_t       crmd_plv,
    output logic       crmd_ie,
    output csr_word_t  ex_entry,
    output csr_word_t  ertn_entry
);

    plv_t                   prmd_pplv;
    logic                   prmd_pie;
    csr_word_t              era;
    logic [31:EENTRY_VA_LSB] eentry_va;
    csr_word_u              crmd_view;
    csr_word_u              prmd_view;
    csr_word_u              crmd_next;
    csr_word_u              prmd_next;
    csr_word_t              era_next;
    csr_word_t              eentry_next;
    logic                   wr_crmd;
    logic                   wr_prmd;
    logic                   wr_era;
    logic                   wr_eentry;

    always_comb begin
        crmd_view          = '0;
        crmd_view.crmd.plv = crmd_plv;
        crmd_view.crmd.ie  = crmd_ie;
        prmd_view           = '0;
        prmd_view.prmd.pplv = prmd_pplv;
        prmd_view.prmd.pie  = prmd_pie;
    end

    assign wr_crmd   = wr.we && (wr.num == CSR_CRMD);
    assign wr_prmd   = wr.we && (wr.num == CSR_PRMD);
    assign wr_era    = wr.we && (wr.num == CSR_ERA);
    assign wr_eentry = wr.we && (wr.num == CSR_EENTRY);

    assign crmd_next.raw = masked_write(crmd_view.raw, wr.wmask, wr.wvalue);
    assign prmd_next.raw = masked_write(prmd_view.raw, wr.wmask, wr.wvalue);
    assign era_next      = masked_write(era, wr.wmask, wr.wvalue);
    assign eentry_next   = masked_write(ex_entry, wr.wmask, wr.wvalue);

    // Exception entry drops to kernel level with interrupts off
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_crmd) begin
            crmd_plv <= crmd_next.crmd.plv;
            crmd_ie  <= crmd_next.crmd.ie;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
            era       <= wb_pc;
        end else begin
            if (wr_prmd) begin
                prmd_pplv <= prmd_next.prmd.pplv;
                prmd_pie  <= prmd_next.prmd.pie;
            end
            if (wr_era) begin
                era <= era_next;
            end
        end
        if (wr_eentry) begin
            eentry_va <= eentry_next[31:EENTRY_VA_LSB];
        end
    end

    assign ex_entry   = {eentry_va, {EENTRY_VA_LSB{1'b0}}};
    assign ertn_entry = era;

    always_comb begin
        case (csr_num)
            CSR_CRMD:   rdata = crmd_view.raw;
            CSR_PRMD:   rdata = prmd_view.raw;
            CSR_ERA:    rdata = era;
            CSR_EENTRY: rdata = ex_entry;
            default:    rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== common/csr_write_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One masked register write, broadcast to every register group
interface csr_write_if import csr_pkg::*; ();

    logic      we;
    csr_num_t  num;
    csr_word_t wmask;
    csr_word_t wvalue;

    modport source (output we, output num, output wmask, output wvalue);
    modport sink   (input we, input num, input wmask, input wvalue);

endinterface

`default_nettype wire

// ==== common/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    typedef logic [13:0] csr_num_t;
    typedef logic [31:0] csr_word_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [1:0]  plv_t;

    // Register numbers
    localparam csr_num_t CSR_CRMD   = 14'h0;
    localparam csr_num_t CSR_PRMD   = 14'h1;
    localparam csr_num_t CSR_ECFG   = 14'h4;
    localparam csr_num_t CSR_ESTAT  = 14'h5;
    localparam csr_num_t CSR_ERA    = 14'h6;
    localparam csr_num_t CSR_EENTRY = 14'hc;
    localparam csr_num_t CSR_SAVE0  = 14'h30;
    localparam csr_num_t CSR_TCFG   = 14'h41;
    localparam csr_num_t CSR_TVAL   = 14'h42;
    localparam csr_num_t CSR_TICLR  = 14'h44;

    localparam int INT_NUM       = 13;
    localparam int TIMER_INT_BIT = 11;
    localparam int IPI_INT_BIT   = 12;
    localparam int HW_INT_LSB    = 2;
    localparam int EENTRY_VA_LSB = 6;

    // Bit 10 of the local interrupt enables is reserved
    localparam logic [INT_NUM-1:0] ECFG_LIE_MASK = 13'h1bff;

    localparam csr_word_t TIMER_IDLE = 32'hffff_ffff;

    typedef struct packed {
        logic [28:0] rsvd;
        logic        ie;
        plv_t        plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] rsvd;
        logic        pie;
        plv_t        pplv;
    } prmd_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    typedef struct packed {
        logic               rsvd_hi;
        esubcode_t          esubcode;
        ecode_t             ecode;
        logic [15-INT_NUM:0] rsvd_lo;
        logic [INT_NUM-1:0] is;
    } estat_t;

    // The same data word decodes differently depending on the target register
    typedef union packed {
        csr_word_t raw;
        crmd_t     crmd;
        prmd_t     prmd;
        tcfg_t     tcfg;
        estat_t    estat;
    } csr_word_u;

    // Bits with a mask bit of 1 take the new value, the others keep the old one
    function automatic csr_word_t masked_write(
        input csr_word_t old_value,
        input csr_word_t wmask,
        input csr_word_t wvalue
    );
        return (wmask & wvalue) | (~wmask & old_value);
    endfunction

endpackage

`default_nettype wire
